// File: src/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    typedef logic [6:0] opcode_t;

    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;

    localparam logic [4:0] REG_RA = 5'd1; // x1 link register
    localparam logic [4:0] REG_T0 = 5'd5; // x5 alternate link

    // conditional branch format
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        opcode_t    opcode;
    } inst_b_t;

    // jump format
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        opcode_t    opcode;
    } inst_j_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_t     opcode;
    } inst_i_t;

    typedef union packed {
        inst_b_t b;
        inst_j_t j;
        inst_i_t i; // also used for opcode and jalr fields
    } inst_u;

endpackage

`default_nettype wire

// File: src/bpu_pkg.sv
`default_nettype none

package bpu_pkg;

    typedef logic [31:0] addr_t;

    // msb set means predict taken
    typedef logic [1:0] ctr_t;

    typedef logic [15:0] hist_t;

    localparam ctr_t CTR_WNT = 2'b01; // weakly not taken

    // default table sizes as powers of two
    localparam int unsigned BHT_ENTRIES = 512;
    localparam int unsigned BTB_ENTRIES = 256;
    localparam int unsigned RAS_DEPTH   = 32;

endpackage

`default_nettype wire

// File: src/bpu_predecode.sv
`default_nettype none

module bpu_predecode (
    input  wire rv_isa_pkg::inst_u inst_i,
    output logic                   is_branch_o,
    output logic                   is_jal_o,
    output logic                   is_jalr_o,
    output logic                   is_ret_o,
    output bpu_pkg::addr_t         b_off_o,
    output bpu_pkg::addr_t         j_off_o
);

    logic link_rs1;

    assign is_branch_o = (inst_i.i.opcode == rv_isa_pkg::OPC_BRANCH);
    assign is_jal_o    = (inst_i.i.opcode == rv_isa_pkg::OPC_JAL);
    assign is_jalr_o   = (inst_i.i.opcode == rv_isa_pkg::OPC_JALR);

    assign link_rs1 = (inst_i.i.rs1 == rv_isa_pkg::REG_RA) ||
                      (inst_i.i.rs1 == rv_isa_pkg::REG_T0);

    // ret is jalr x0, 0(ra) or the t0 variant
    assign is_ret_o = is_jalr_o && (inst_i.i.rd == 5'd0) && link_rs1 &&
                      (inst_i.i.imm12 == 12'd0);

    // b offset with bit 0 always zero
    assign b_off_o = {{19{inst_i.b.imm12}},
                      inst_i.b.imm12,
                      inst_i.b.imm11,
                      inst_i.b.imm10_5,
                      inst_i.b.imm4_1,
                      1'b0};

    assign j_off_o = {{11{inst_i.j.imm20}},
                      inst_i.j.imm20,
                      inst_i.j.imm19_12,
                      inst_i.j.imm11,
                      inst_i.j.imm10_1,
                      1'b0}; // +-1 MiB range

endmodule

`default_nettype wire

// File: src/bimodal_bht.sv
`default_nettype none

module bimodal_bht #(
    parameter int unsigned ENTRIES = bpu_pkg::BHT_ENTRIES
) (
    input  wire                 clk,
    input  wire                 rst,
    input  wire bpu_pkg::addr_t rd_pc_i,
    input  wire                 upd_valid_i,
    input  wire                 upd_taken_i,
    input  wire bpu_pkg::addr_t upd_pc_i,
    output bpu_pkg::ctr_t       rd_ctr_o
);

    localparam int unsigned IDX_W = $clog2(ENTRIES);

    bpu_pkg::ctr_t    ctr_q [ENTRIES];
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] upd_idx;
    bpu_pkg::ctr_t    upd_ctr;

    // halfword granularity so compressed code spreads out too
    assign rd_idx  = rd_pc_i[IDX_W:1];
    assign upd_idx = upd_pc_i[IDX_W:1];

    assign rd_ctr_o = ctr_q[rd_idx];

    // saturating step
    always_comb begin
        upd_ctr = ctr_q[upd_idx];
        if (upd_taken_i) begin
            if (upd_ctr != 2'b11) begin
                upd_ctr = upd_ctr + 2'b01;
            end
        end else begin
            if (upd_ctr != 2'b00) begin
                upd_ctr = upd_ctr - 2'b01;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int k = 0; k < ENTRIES; k++) begin
                ctr_q[k] <= bpu_pkg::CTR_WNT;
            end
        end else if (upd_valid_i) begin
            ctr_q[upd_idx] <= upd_ctr;
        end
    end

endmodule

`default_nettype wire

// File: src/bpu_btb.sv
`default_nettype none

module bpu_btb #(
    parameter int unsigned ENTRIES = bpu_pkg::BTB_ENTRIES
) (
    input  wire                 clk,
    input  wire                 rst,
    input  wire bpu_pkg::addr_t rd_pc_i,
    input  wire                 wr_en_i,
    input  wire bpu_pkg::addr_t wr_pc_i,
    input  wire bpu_pkg::addr_t wr_target_i,
    output logic                hit_o,
    output bpu_pkg::addr_t      target_o
);

    localparam int unsigned IDX_W = $clog2(ENTRIES);
    localparam int unsigned TAG_W = 32 - 2 - IDX_W; // everything above the index

    logic                 valid_q  [ENTRIES];
    logic [TAG_W-1:0]     tag_q    [ENTRIES];
    bpu_pkg::addr_t       target_q [ENTRIES];

    logic [IDX_W-1:0]     rd_idx;
    logic [TAG_W-1:0]     rd_tag;
    logic [IDX_W-1:0]     wr_idx;
    logic [TAG_W-1:0]     wr_tag;

    assign rd_idx = rd_pc_i[IDX_W+1:2];
    assign rd_tag = rd_pc_i[31:IDX_W+2];
    assign wr_idx = wr_pc_i[IDX_W+1:2];
    assign wr_tag = wr_pc_i[31:IDX_W+2];

    // full tag compare so a pc never hits on another's entry
    assign hit_o    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    assign target_o = target_q[rd_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int k = 0; k < ENTRIES; k++) begin
                valid_q[k] <= 1'b0;
            end
        end else if (wr_en_i) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // filled only on taken branches
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            tag_q[wr_idx]    <= wr_tag;
            target_q[wr_idx] <= wr_target_i;
        end
    end

endmodule

`default_nettype wire

// File: src/return_stack.sv
`default_nettype none

module return_stack #(
    parameter int unsigned DEPTH = bpu_pkg::RAS_DEPTH
) (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 push_i,
    input  wire bpu_pkg::addr_t push_data_i,
    input  wire                 pop_i,
    input  wire                 stall_i,
    output bpu_pkg::addr_t      top_o,
    output logic                empty_o
);

    localparam int unsigned PTR_W = $clog2(DEPTH);

    bpu_pkg::addr_t   stack_q [DEPTH];
    logic [PTR_W:0]   sp;          // number of valid entries
    logic [PTR_W:0]   sp_popped;
    logic [PTR_W-1:0] top_idx;
    logic             do_pop;
    logic             do_push;

    assign empty_o = (sp == '0);

    // wraps to DEPTH-1 when full
    assign top_idx = sp[PTR_W-1:0] - 1'b1;
    assign top_o   = stack_q[top_idx];

    assign do_pop    = pop_i && !stall_i && !empty_o;
    assign sp_popped = do_pop ? sp - 1'b1 : sp;

    // push sees the stack after the pop
    assign do_push = push_i && !stall_i && (sp_popped != (PTR_W+1)'(DEPTH));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sp <= '0;
        end else begin
            sp <= do_push ? sp_popped + 1'b1 : sp_popped;
        end
    end

    // pop plus push overwrites the old top
    always_ff @(posedge clk) begin
        if (do_push) begin
            stack_q[sp_popped[PTR_W-1:0]] <= push_data_i;
        end
    end

endmodule

`default_nettype wire

// File: src/pred_select.sv
`default_nettype none

module pred_select (
    input  wire bpu_pkg::addr_t pc_i,
    input  wire                 is_branch_i,
    input  wire                 is_jal_i,
    input  wire                 is_jalr_i,
    input  wire                 is_ret_i,
    input  wire bpu_pkg::addr_t b_off_i,
    input  wire bpu_pkg::addr_t j_off_i,
    input  wire bpu_pkg::ctr_t  ctr_i,
    input  wire                 btb_hit_i,
    input  wire bpu_pkg::addr_t btb_target_i,
    input  wire bpu_pkg::addr_t ras_top_i,
    input  wire                 ras_empty_i,
    output logic                branch_o,
    output logic                taken_o,
    output bpu_pkg::addr_t      target_o
);

    bpu_pkg::addr_t pc_plus4;
    bpu_pkg::addr_t b_target;
    bpu_pkg::addr_t j_target;

    assign pc_plus4 = pc_i + 32'd4;
    assign b_target = pc_i + b_off_i;
    assign j_target = pc_i + j_off_i;

    always_comb begin
        branch_o = is_branch_i || is_jal_i || is_jalr_i;
        taken_o  = 1'b0;
        target_o = pc_plus4; // fall through by default

        if (is_ret_i) begin
            if (!ras_empty_i) begin
                taken_o  = 1'b1;
                target_o = ras_top_i;
            end
        end else if (is_jal_i) begin
            taken_o  = 1'b1;
            target_o = btb_hit_i ? btb_target_i : j_target;
        end else if (is_branch_i) begin
            taken_o = ctr_i[1];
            if (ctr_i[1]) begin
                target_o = btb_hit_i ? btb_target_i : b_target;
            end
        end else if (is_jalr_i) begin
            // indirect jump whose target only the btb knows
            taken_o = ctr_i[1];
            if (ctr_i[1] && btb_hit_i) begin
                target_o = btb_target_i;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/bpu_top.sv
`default_nettype none

module bpu_top #(
    parameter int unsigned BHT_ENTRIES = bpu_pkg::BHT_ENTRIES,
    parameter int unsigned BTB_ENTRIES = bpu_pkg::BTB_ENTRIES,
    parameter int unsigned RAS_DEPTH   = bpu_pkg::RAS_DEPTH
) (
    input  wire                    clk,
    input  wire                    rst,
    // fetch
    input  wire bpu_pkg::addr_t    if_pc_i,
    input  wire rv_isa_pkg::inst_u if_inst_i,
    // execute feedback
    input  wire                    ex_branch_valid_i,
    input  wire                    ex_branch_taken_i,
    input  wire bpu_pkg::addr_t    ex_pc_i,
    input  wire bpu_pkg::addr_t    ex_target_i,
    input  wire rv_isa_pkg::inst_u ex_inst_i,
    // decode call push
    input  wire                    id_ras_push_valid_i,
    input  wire bpu_pkg::addr_t    id_ras_push_data_i,
    input  wire                    stall_i,
    output logic                   branch_o,
    output logic                   pred_taken_o,
    output bpu_pkg::addr_t         pred_target_o,
    output bpu_pkg::hist_t         history_o
);

    bpu_pkg::hist_t history_q;

    logic           if_is_branch;
    logic           if_is_jal;
    logic           if_is_jalr;
    logic           if_is_ret;
    bpu_pkg::addr_t if_b_off;
    bpu_pkg::addr_t if_j_off;
    logic           ex_is_ret;

    bpu_pkg::ctr_t  bht_ctr;
    logic           btb_hit;
    bpu_pkg::addr_t btb_target;
    bpu_pkg::addr_t ras_top;
    logic           ras_empty;
    logic           ras_pop;

    // newest outcome at bit 0
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            history_q <= '0;
        end else if (ex_branch_valid_i) begin
            history_q <= {history_q[$bits(bpu_pkg::hist_t)-2:0], ex_branch_taken_i};
        end
    end

    assign history_o = history_q;

    // pop on a resolved taken return
    assign ras_pop = ex_branch_valid_i && ex_branch_taken_i && ex_is_ret;

    bpu_predecode i_if_decode (
        .inst_i      (if_inst_i),
        .is_branch_o (if_is_branch),
        .is_jal_o    (if_is_jal),
        .is_jalr_o   (if_is_jalr),
        .is_ret_o    (if_is_ret),
        .b_off_o     (if_b_off),
        .j_off_o     (if_j_off)
    );

    bpu_predecode i_ex_decode (
        .inst_i      (ex_inst_i),
        .is_branch_o (),
        .is_jal_o    (),
        .is_jalr_o   (),
        .is_ret_o    (ex_is_ret),
        .b_off_o     (),
        .j_off_o     ()
    );

    bimodal_bht #(
        .ENTRIES (BHT_ENTRIES)
    ) i_bht (
        .clk         (clk),
        .rst         (rst),
        .rd_pc_i     (if_pc_i),
        .upd_valid_i (ex_branch_valid_i),
        .upd_taken_i (ex_branch_taken_i),
        .upd_pc_i    (ex_pc_i),
        .rd_ctr_o    (bht_ctr)
    );

    bpu_btb #(
        .ENTRIES (BTB_ENTRIES)
    ) i_btb (
        .clk         (clk),
        .rst         (rst),
        .rd_pc_i     (if_pc_i),
        .wr_en_i     (ex_branch_valid_i && ex_branch_taken_i),
        .wr_pc_i     (ex_pc_i),
        .wr_target_i (ex_target_i),
        .hit_o       (btb_hit),
        .target_o    (btb_target)
    );

    return_stack #(
        .DEPTH (RAS_DEPTH)
    ) i_ras (
        .clk         (clk),
        .rst         (rst),
        .push_i      (id_ras_push_valid_i),
        .push_data_i (id_ras_push_data_i),
        .pop_i       (ras_pop),
        .stall_i     (stall_i),
        .top_o       (ras_top),
        .empty_o     (ras_empty)
    );

    pred_select i_select (
        .pc_i         (if_pc_i),
        .is_branch_i  (if_is_branch),
        .is_jal_i     (if_is_jal),
        .is_jalr_i    (if_is_jalr),
        .is_ret_i     (if_is_ret),
        .b_off_i      (if_b_off),
        .j_off_i      (if_j_off),
        .ctr_i        (bht_ctr),
        .btb_hit_i    (btb_hit),
        .btb_target_i (btb_target),
        .ras_top_i    (ras_top),
        .ras_empty_i  (ras_empty),
        .branch_o     (branch_o),
        .taken_o      (pred_taken_o),
        .target_o     (pred_target_o)
    );

endmodule

`default_nettype wire

// File: test/bpu_asserts.sv
`default_nettype none

module bpu_asserts #(
    parameter int unsigned SP_W = 6
) (
    input wire                 clk,
    input wire                 rst,
    input wire bpu_pkg::addr_t pc_i,
    input wire                 branch_i,
    input wire                 taken_i,
    input wire bpu_pkg::addr_t target_i,
    input wire                 is_ret_i,
    input wire                 ras_empty_i,
    input wire                 stall_i,
    input wire [SP_W-1:0]      ras_sp_i
);

    int unsigned fail_count = 0; // failed properties so far

    // non-control words fall through
    a_fall_through: assert property (@(posedge clk) disable iff (rst)
        !branch_i |-> (!taken_i && target_i == pc_i + 32'd4))
        else begin
            fail_count++;
            $error("non-control word predicted taken or not at pc+4");
        end

    a_ret_empty: assert property (@(posedge clk) disable iff (rst)
        (is_ret_i && ras_empty_i) |-> !taken_i)
        else begin
            fail_count++;
            $error("return predicted taken with an empty ras");
        end

    a_stall_freeze: assert property (@(posedge clk) disable iff (rst)
        stall_i |=> $stable(ras_sp_i))
        else begin
            fail_count++;
            $error("ras pointer moved during a stall");
        end

endmodule

bind bpu_top bpu_asserts #(
    .SP_W ($clog2(RAS_DEPTH) + 1)
) i_asserts (
    .clk         (clk),
    .rst         (rst),
    .pc_i        (if_pc_i),
    .branch_i    (branch_o),
    .taken_i     (pred_taken_o),
    .target_i    (pred_target_o),
    .is_ret_i    (if_is_ret),
    .ras_empty_i (ras_empty),
    .stall_i     (stall_i),
    .ras_sp_i    (i_ras.sp)
);

`default_nettype wire

// File: test/bpu_tb.sv
`default_nettype none

module bpu_tb;

    localparam int unsigned CLK_PERIOD = 4;
    localparam int unsigned RST_CYCLES = 8;
    localparam int unsigned NUM_CYCLES = 3000;
    localparam int unsigned BHT_W      = $clog2(bpu_pkg::BHT_ENTRIES);
    localparam int unsigned BTB_W      = $clog2(bpu_pkg::BTB_ENTRIES);

    // instruction kinds drawn per cycle
    localparam int K_BR    = 0;
    localparam int K_JAL   = 1;
    localparam int K_RET   = 2;
    localparam int K_JALR  = 3;
    localparam int K_OTHER = 4;

    logic              clk;
    logic              rst;
    bpu_pkg::addr_t    if_pc;
    rv_isa_pkg::inst_u if_inst;
    logic              ex_valid;
    logic              ex_taken;
    bpu_pkg::addr_t    ex_pc;
    bpu_pkg::addr_t    ex_target;
    rv_isa_pkg::inst_u ex_inst;
    logic              push_valid;
    bpu_pkg::addr_t    push_data;
    logic              stall;
    logic              branch;
    logic              pred_taken;
    bpu_pkg::addr_t    pred_target;
    bpu_pkg::hist_t    history;

    // reference model state
    bpu_pkg::ctr_t  m_ctr       [bpu_pkg::BHT_ENTRIES];
    logic           m_btb_valid [bpu_pkg::BTB_ENTRIES];
    bpu_pkg::addr_t m_btb_tag   [bpu_pkg::BTB_ENTRIES];
    bpu_pkg::addr_t m_btb_tgt   [bpu_pkg::BTB_ENTRIES];
    bpu_pkg::addr_t m_ras       [bpu_pkg::RAS_DEPTH];
    int unsigned    m_sp;
    bpu_pkg::hist_t m_hist;
    int             cur_kind;   // kind of the word on if_inst
    bpu_pkg::addr_t cur_off;
    logic           ex_is_ret;

    logic [6:0] plain_opc [4] = '{7'b0110011, 7'b0010011, 7'b0000011, 7'b0100011};

    always #(CLK_PERIOD / 2) clk = ~clk;

    bpu_top #(
        .BHT_ENTRIES (bpu_pkg::BHT_ENTRIES),
        .BTB_ENTRIES (bpu_pkg::BTB_ENTRIES),
        .RAS_DEPTH   (bpu_pkg::RAS_DEPTH)
    ) i_dut (
        .clk                 (clk),
        .rst                 (rst),
        .if_pc_i             (if_pc),
        .if_inst_i           (if_inst),
        .ex_branch_valid_i   (ex_valid),
        .ex_branch_taken_i   (ex_taken),
        .ex_pc_i             (ex_pc),
        .ex_target_i         (ex_target),
        .ex_inst_i           (ex_inst),
        .id_ras_push_valid_i (push_valid),
        .id_ras_push_data_i  (push_data),
        .stall_i             (stall),
        .branch_o            (branch),
        .pred_taken_o        (pred_taken),
        .pred_target_o       (pred_target),
        .history_o           (history)
    );

    // four tags over sixteen btb slots so entries alias
    function automatic bpu_pkg::addr_t pool_pc();
        return ($urandom_range(1, 4) << (BTB_W + 2)) | ($urandom_range(0, 15) << 2);
    endfunction

    task automatic make_inst(input int kind, output logic [31:0] word,
                             output bpu_pkg::addr_t off);
        logic [31:0] imm;
        logic [4:0]  rd;
        imm  = $urandom;
        word = $urandom;
        off  = '0;
        case (kind)
            K_BR: begin
                off  = {{19{imm[12]}}, imm[12:1], 1'b0};
                word = {off[12], off[10:5], word[24:12], off[4:1], off[11], 7'b1100011};
            end
            K_JAL: begin
                off  = {{11{imm[20]}}, imm[20:1], 1'b0};
                word = {off[20], off[10:1], off[11], off[19:12], word[11:7], 7'b1101111};
            end
            K_RET: word = {12'd0, (imm[0] ? 5'd1 : 5'd5), 3'b000, 5'd0, 7'b1100111};
            K_JALR: begin
                rd   = (imm[4:0] == 5'd0) ? 5'd1 : imm[4:0]; // nonzero rd so never a return
                word = {word[31:12], rd, 7'b1100111};
            end
            default: word = {word[31:7], plain_opc[imm[1:0]]};
        endcase
    endtask

    task automatic reset_model();
        for (int k = 0; k < bpu_pkg::BHT_ENTRIES; k++) begin
            m_ctr[k] = 2'd1;
        end
        for (int k = 0; k < bpu_pkg::BTB_ENTRIES; k++) begin
            m_btb_valid[k] = 1'b0;
        end
        m_sp   = 0;
        m_hist = '0;
    endtask

    task automatic drive_inputs(input int unsigned cycle);
        logic [31:0]    word;
        bpu_pkg::addr_t off;
        int             kind;
        int             ex_kind;
        logic           drain;
        drain = ((cycle / 250) % 2) == 1; // alternate filling and draining the ras
        kind  = $urandom_range(0, 4);
        make_inst(kind, word, off);
        if_pc    <= pool_pc();
        if_inst  <= word;
        cur_kind <= kind;
        cur_off  <= off;
        ex_kind = (drain && $urandom_range(0, 9) < 6) ? K_RET : $urandom_range(0, 4);
        make_inst(ex_kind, word, off);
        ex_inst    <= word;
        ex_is_ret  <= (ex_kind == K_RET);
        ex_valid   <= $urandom_range(0, 1) == 1;
        ex_taken   <= $urandom_range(0, 1) == 1;
        ex_pc      <= pool_pc();
        ex_target  <= $urandom & ~32'd3;
        push_valid <= $urandom_range(0, 99) < (drain ? 5 : 50);
        push_data  <= $urandom & ~32'd3;
        stall      <= $urandom_range(0, 9) == 0;
    endtask

    // called at the edge before the new inputs land
    task automatic update_model();
        int unsigned bi;
        int unsigned ti;
        int unsigned sp_next;
        bi = ex_pc[BHT_W:1];
        ti = ex_pc[BTB_W+1:2];
        if (ex_valid) begin
            m_hist = {m_hist[$bits(bpu_pkg::hist_t)-2:0], ex_taken};
            if (ex_taken) begin
                m_ctr[bi]       = (m_ctr[bi] == 2'd3) ? 2'd3 : m_ctr[bi] + 2'd1;
                m_btb_valid[ti] = 1'b1;
                m_btb_tag[ti]   = ex_pc >> (BTB_W + 2);
                m_btb_tgt[ti]   = ex_target;
            end else begin
                m_ctr[bi] = (m_ctr[bi] == 2'd0) ? 2'd0 : m_ctr[bi] - 2'd1;
            end
        end
        if (!stall) begin
            sp_next = m_sp;
            if (ex_valid && ex_taken && ex_is_ret && sp_next != 0) begin
                sp_next--;
            end
            if (push_valid && sp_next != bpu_pkg::RAS_DEPTH) begin
                m_ras[sp_next] = push_data;
                sp_next++;
            end
            m_sp = sp_next;
        end
    endtask

    task automatic check_pred(input bpu_pkg::addr_t exp_target, input logic exp_taken,
                              input logic exp_branch);
        if (branch !== exp_branch || pred_taken !== exp_taken || pred_target !== exp_target) begin
            $display("FAILED at %0t: pc %h kind %0d got branch %b taken %b target %h",
                     $time, if_pc, cur_kind, branch, pred_taken, pred_target);
            $display("FAILED at %0t: expected branch %b taken %b target %h",
                     $time, exp_branch, exp_taken, exp_target);
            $display("RESULT: FAIL");
            $fatal(1, "prediction mismatch");
        end
    endtask

    task automatic check_history(input bpu_pkg::hist_t exp_hist);
        if (history !== exp_hist) begin
            $display("FAILED at %0t: history %h, expected %h", $time, history, exp_hist);
            $display("RESULT: FAIL");
            $fatal(1, "history mismatch");
        end
    endtask

    // the bound checker counts its failed properties
    task automatic check_asserts();
        if (i_dut.i_asserts.fail_count != 0) begin
            $display("a bound assertion on the DUT failed before time %0t", $time);
            $display("RESULT: FAIL");
            $fatal(1, "assertion failure");
        end
    endtask

    task automatic check_outputs();
        bpu_pkg::addr_t tgt;
        logic           tk;
        logic           hit;
        bpu_pkg::ctr_t  ctr;
        int unsigned    ti;
        ti  = if_pc[BTB_W+1:2];
        ctr = m_ctr[if_pc[BHT_W:1]];
        hit = m_btb_valid[ti] && (m_btb_tag[ti] == (if_pc >> (BTB_W + 2)));
        tk  = 1'b0;
        tgt = if_pc + 32'd4;
        case (cur_kind)
            K_RET: begin
                if (m_sp != 0) begin
                    tk  = 1'b1;
                    tgt = m_ras[m_sp-1];
                end
            end
            K_JAL: begin
                tk  = 1'b1;
                tgt = hit ? m_btb_tgt[ti] : if_pc + cur_off;
            end
            K_BR: begin
                tk = ctr[1];
                if (tk) begin
                    tgt = hit ? m_btb_tgt[ti] : if_pc + cur_off;
                end
            end
            K_JALR: begin
                tk = ctr[1];
                if (tk && hit) begin
                    tgt = m_btb_tgt[ti];
                end
            end
            default: ;
        endcase
        check_pred(tgt, tk, cur_kind != K_OTHER);
        check_history(m_hist);
    endtask

    initial begin
        void'($urandom(3778));
        clk        = 1'b0;
        rst        = 1'b1;
        if_pc      = '0;
        if_inst    = '0;
        ex_valid   = 1'b0;
        ex_taken   = 1'b0;
        ex_pc      = '0;
        ex_target  = '0;
        ex_inst    = '0;
        push_valid = 1'b0;
        push_data  = '0;
        stall      = 1'b0;
        cur_kind   = K_OTHER;
        cur_off    = '0;
        ex_is_ret  = 1'b0;
        reset_model();
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
        drive_inputs(0);
        for (int unsigned n = 1; n <= NUM_CYCLES; n++) begin
            @(negedge clk); // outputs settled mid cycle
            check_outputs();
            check_asserts();
            @(posedge clk);
            update_model();
            drive_inputs(n);
        end
        @(negedge clk); // let the last edge's properties resolve
        check_asserts();
        $display("RESULT: PASS");
        $finish;
    end

    initial begin
        #((RST_CYCLES + NUM_CYCLES) * CLK_PERIOD + 200);
        $display("timeout: the test loop did not finish in the expected time");
        $display("RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// File: tb.f
src/rv_isa_pkg.sv
src/bpu_pkg.sv
src/bpu_predecode.sv
src/bimodal_bht.sv
src/bpu_btb.sv
src/return_stack.sv
src/pred_select.sv
src/bpu_top.sv
test/bpu_asserts.sv
test/bpu_tb.sv

// File: Bender.yml
package:
  name: bpu

sources:
  - src/rv_isa_pkg.sv
  - src/bpu_pkg.sv
  - src/bpu_predecode.sv
  - src/bimodal_bht.sv
  - src/bpu_btb.sv
  - src/return_stack.sv
  - src/pred_select.sv
  - src/bpu_top.sv
  - target: test
    files:
      - test/bpu_asserts.sv
      - test/bpu_tb.sv
